/* rtl/fetchPkg.sv */
// Front-end package with widths, opcodes, decode enums, control and issue record types
package fetchPkg;

   localparam int pcWidth   = 16;  // PC and instruction word width
   localparam int regAddrW  = 3;   // Register file index
   localparam int imemDepth = 256;
   localparam int imemAddrW = $clog2(imemDepth);  // ROM index taken from pc[8:1]
   localparam int sbDepth   = 3;   // Issued instructions tracked for RAW

   localparam logic [pcWidth-1:0] nopWord = 16'h0800;

   // Immediate formats seen by execute
   localparam logic [2:0] imm5Sext  = 3'd0;
   localparam logic [2:0] imm8Sext  = 3'd2;
   localparam logic [2:0] imm11Sext = 3'd4;

   typedef enum logic [4:0] {
      opHalt = 5'b00000,
      opNop  = 5'b00001,
      opJ    = 5'b00100,
      opJr   = 5'b00101,
      opJal  = 5'b00110,
      opAddi = 5'b01000,
      opSubi = 5'b01001,
      opBeqz = 5'b01100,
      opSt   = 5'b10000,
      opLd   = 5'b10001,
      opLbi  = 5'b11000,
      opAlu  = 5'b11011
   } opcodeE;

   // Which instruction field names the written register
   typedef enum logic [1:0] {
      dstRs  = 2'b00,  // bits 10:8
      dstRdR = 2'b01,  // bits 4:2
      dstR7  = 2'b10,
      dstRdI = 2'b11   // bits 7:5
   } destSelE;

   typedef struct packed {
      logic       regWrite;
      destSelE    destSel;
      logic       memEnable;
      logic       memWr;
      logic       val2Reg;   // Writeback takes memory data
      logic       aluSel;    // Second ALU operand is the immediate
      logic [2:0] immSel;
      logic       halt;
      logic       link;
      logic       lbi;
      logic       regJmp;
      logic       bFlag;
      logic       jFlag;
      logic       ctrlErr;
      logic       validRs;   // Opcode reads bits 10:8
      logic       validRt;   // Opcode reads bits 7:5
   } ctrlT;

   typedef struct packed {
      logic                valid;
      logic [pcWidth-1:0]  pc;
      logic [pcWidth-1:0]  instr;
      logic [regAddrW-1:0] writeRegAddr;
      ctrlT                ctrl;
   } issueT;

endpackage

/* rtl/progCounter.sv */
// Program counter register and next-address priority mux
`timescale 1ns/10ps

module progCounter (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          stall,
   input  logic                          halted,
   input  logic                          pcSel,
   input  logic                          jump,
   input  logic [fetchPkg::pcWidth-1:0]  brnchAddr,
   input  logic [fetchPkg::pcWidth-1:0]  jumpTarget,
   output logic [fetchPkg::pcWidth-1:0]  pc
);

   logic [fetchPkg::pcWidth-1:0] pcNext;
   logic [fetchPkg::pcWidth-1:0] pcInc;

   assign pcInc = pc + 16'd2;

   // Downstream redirect wins over everything, even a halt
   always_comb begin
      if (pcSel) begin
         pcNext = brnchAddr;
      end
      else if (halted || stall) begin
         pcNext = pc;        // Hold on hazard or after HALT
      end
      else if (jump) begin
         pcNext = jumpTarget;
      end
      else begin
         pcNext = pcInc;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc <= '0;
      end
      else begin
         pc <= pcNext;
      end
   end

endmodule

/* rtl/instrMem.sv */
// Word-addressed instruction ROM with combinational read
`timescale 1ns/10ps

module instrMem (
   input  logic [fetchPkg::pcWidth-1:0] addr,
   output logic [fetchPkg::pcWidth-1:0] data
);

   logic [fetchPkg::pcWidth-1:0] rom [fetchPkg::imemDepth];

   // Words past the end of the program fetch as NOP
   initial begin
      for (int i = 0; i < fetchPkg::imemDepth; i++) begin
         rom[i] = fetchPkg::nopWord;
      end
      $readmemh("imem.hex", rom);
   end

   // Byte address, so bit 0 is dropped
   assign data = rom[addr[fetchPkg::imemAddrW:1]];

endmodule

/* rtl/ctrlDecoder.sv */
// Opcode to control-set decoder
`timescale 1ns/10ps

module ctrlDecoder (
   input  fetchPkg::opcodeE opcode,
   output fetchPkg::ctrlT   ctrl
);

   always_comb begin
      ctrl = '0;
      case (opcode)
         fetchPkg::opHalt: begin
            ctrl.halt = 1'b1;
         end
         fetchPkg::opNop: begin
            ctrl = '0;          // Bubble, nothing set
         end
         fetchPkg::opJ: begin
            ctrl.jFlag  = 1'b1;
            ctrl.immSel = fetchPkg::imm11Sext;
         end
         fetchPkg::opJr: begin
            ctrl.jFlag   = 1'b1;
            ctrl.regJmp  = 1'b1;   // Target from Rs, resolved downstream
            ctrl.immSel  = fetchPkg::imm8Sext;
            ctrl.validRs = 1'b1;
         end
         fetchPkg::opJal: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = fetchPkg::dstR7;
            ctrl.link     = 1'b1;
            ctrl.jFlag    = 1'b1;
            ctrl.immSel   = fetchPkg::imm11Sext;
         end
         fetchPkg::opAddi, fetchPkg::opSubi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = fetchPkg::dstRdI;
            ctrl.aluSel   = 1'b1;
            ctrl.immSel   = fetchPkg::imm5Sext;
            ctrl.validRs  = 1'b1;
         end
         fetchPkg::opBeqz: begin
            ctrl.bFlag   = 1'b1;
            ctrl.immSel  = fetchPkg::imm8Sext;
            ctrl.validRs = 1'b1;
         end
         fetchPkg::opSt: begin
            ctrl.memEnable = 1'b1;
            ctrl.memWr     = 1'b1;
            ctrl.aluSel    = 1'b1;
            ctrl.immSel    = fetchPkg::imm5Sext;
            ctrl.validRs   = 1'b1;   // Base address
            ctrl.validRt   = 1'b1;   // Store data
         end
         fetchPkg::opLd: begin
            ctrl.regWrite  = 1'b1;
            ctrl.destSel   = fetchPkg::dstRdI;
            ctrl.memEnable = 1'b1;
            ctrl.val2Reg   = 1'b1;
            ctrl.aluSel    = 1'b1;
            ctrl.immSel    = fetchPkg::imm5Sext;
            ctrl.validRs   = 1'b1;
         end
         fetchPkg::opLbi: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = fetchPkg::dstRs;  // LBI writes the Rs field
            ctrl.lbi      = 1'b1;
            ctrl.immSel   = fetchPkg::imm8Sext;
         end
         fetchPkg::opAlu: begin
            ctrl.regWrite = 1'b1;
            ctrl.destSel  = fetchPkg::dstRdR;
            ctrl.validRs  = 1'b1;
            ctrl.validRt  = 1'b1;
         end
         default: begin
            // Unknown opcode flags an error and nothing else
            ctrl         = '0;
            ctrl.ctrlErr = 1'b1;
         end
      endcase
   end

endmodule

/* rtl/hazardUnit.sv */
// Destination scoreboard over the last three issues and RAW stall detect
`timescale 1ns/10ps

module hazardUnit (
   input  logic                           clk,
   input  logic                           rstN,
   input  logic [fetchPkg::regAddrW-1:0]  rsAddr,
   input  logic [fetchPkg::regAddrW-1:0]  rtAddr,
   input  logic                           validRs,
   input  logic                           validRt,
   input  logic                           regWrite,
   input  logic                           halted,
   input  logic [fetchPkg::regAddrW-1:0]  destAddr,
   output logic                           stall
);

   typedef struct packed {
      logic                          valid;
      logic [fetchPkg::regAddrW-1:0] addr;
   } sbEntryT;

   // Entry 0 is the most recent issue
   sbEntryT [fetchPkg::sbDepth-1:0] sb;
   sbEntryT                         sbIn;

   logic rsHit;
   logic rtHit;

   always_comb begin
      rsHit = 1'b0;
      rtHit = 1'b0;
      for (int i = 0; i < fetchPkg::sbDepth; i++) begin
         rsHit = rsHit | (sb[i].valid && (sb[i].addr == rsAddr));
         rtHit = rtHit | (sb[i].valid && (sb[i].addr == rtAddr));
      end
   end

   // Only sources the opcode really reads can stall
   assign stall = (validRs && rsHit) || (validRt && rtHit);

   // A stalled or halted slot issues a NOP, so it enters as a bubble
   always_comb begin
      sbIn.valid = regWrite && !stall && !halted;
      sbIn.addr  = destAddr;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         sb <= '0;
      end
      else begin
         sb <= {sb[fetchPkg::sbDepth-2:0], sbIn};  // Shift every cycle
      end
   end

endmodule

/* rtl/fetchStage.sv */
// Fetch-and-issue top with jump adder, halt flag and issue register
`timescale 1ns/10ps

module fetchStage (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          pcSel,
   input  logic [fetchPkg::pcWidth-1:0]  brnchAddr,
   output fetchPkg::issueT               issue,
   output logic [fetchPkg::pcWidth-1:0]  pc
);

   logic [fetchPkg::pcWidth-1:0]  fetchWord;
   logic [fetchPkg::pcWidth-1:0]  issueWord;
   logic [fetchPkg::pcWidth-1:0]  jumpTarget;
   logic [fetchPkg::regAddrW-1:0] fetchDest;
   logic [fetchPkg::regAddrW-1:0] issueDest;
   fetchPkg::opcodeE              fetchOp;
   fetchPkg::ctrlT                fetchCtrl;
   fetchPkg::ctrlT                issueCtrl;
   fetchPkg::issueT               issueNext;
   logic                          stall;
   logic                          halted;
   logic                          useNop;
   logic                          jumpReq;

   function automatic logic [fetchPkg::regAddrW-1:0] pickDest(
      input logic [fetchPkg::pcWidth-1:0] word,
      input fetchPkg::destSelE            sel
   );
      case (sel)
         fetchPkg::dstRs:  pickDest = word[10:8];
         fetchPkg::dstRdR: pickDest = word[4:2];
         fetchPkg::dstR7:  pickDest = 3'd7;
         default:          pickDest = word[7:5];  // Rd of I-format
      endcase
   endfunction

   progCounter progCounter_i (
      .clk(clk), .rstN(rstN), .stall(stall), .halted(halted),
      .pcSel(pcSel), .jump(jumpReq), .brnchAddr(brnchAddr),
      .jumpTarget(jumpTarget), .pc(pc)
   );

   instrMem instrMem_i (.addr(pc), .data(fetchWord));

   assign fetchOp = fetchPkg::opcodeE'(fetchWord[15:11]);

   ctrlDecoder fetchDecoder_i (.opcode(fetchOp), .ctrl(fetchCtrl));

   assign fetchDest = pickDest(fetchWord, fetchCtrl.destSel);

   hazardUnit hazardUnit_i (
      .clk(clk), .rstN(rstN),
      .rsAddr(fetchWord[10:8]), .rtAddr(fetchWord[7:5]),
      .validRs(fetchCtrl.validRs), .validRt(fetchCtrl.validRt),
      .regWrite(fetchCtrl.regWrite), .halted(halted),
      .destAddr(fetchDest), .stall(stall)
   );

   // Direct jumps resolve here, pc + 2 + sext(disp11)
   assign jumpTarget = pc + 16'd2 + {{5{fetchWord[10]}}, fetchWord[10:0]};
   assign jumpReq    = ((fetchOp == fetchPkg::opJ) || (fetchOp == fetchPkg::opJal)) && !stall;

   assign useNop    = stall || halted;
   assign issueWord = useNop ? fetchPkg::nopWord : fetchWord;

   ctrlDecoder issueDecoder_i (
      .opcode(fetchPkg::opcodeE'(issueWord[15:11])),
      .ctrl(issueCtrl)
   );

   assign issueDest = pickDest(issueWord, issueCtrl.destSel);

   always_comb begin
      issueNext.valid        = !useNop;
      issueNext.pc           = pc;
      issueNext.instr        = issueWord;
      issueNext.writeRegAddr = issueDest;
      issueNext.ctrl         = issueCtrl;
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
      end
      else if (fetchCtrl.halt && !useNop) begin
         halted <= 1'b1;   // Sticky until reset
      end
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         issue       <= '0;
         issue.instr <= fetchPkg::nopWord;
      end
      else begin
         issue <= issueNext;
      end
   end

endmodule

/* dv/fetchStageTb.sv */
// Testbench for the fetch front end with reference model, redirect stimulus and checker
`timescale 1ns/10ps

module fetchStageTb;

   logic                  clk;
   logic                  rstN;
   logic                  pcSel;
   logic [15:0]           brnchAddr;
   fetchPkg::issueT       issue;
   logic [15:0]           pc;

   logic [15:0]           progMem [256];  // Copy of the program for the model
   integer                seed;
   integer                errCount;
   integer                checkCount;
   integer                cycle;
   logic                  haltSeen;
   logic                  timedOut;
   logic [15:0]           frozenPc;
   logic                  stallRedir;     // Redirect already placed on a stall

   // Model state
   logic [15:0]           mPc;
   logic [2:0]            mSbV;
   logic [2:0][2:0]       mSbA;
   logic                  mHalted;
   logic                  mStallNext;     // Next fetch hits the scoreboard
   fetchPkg::issueT       expIssue;

   fetchStage fetchStage_i (
      .clk(clk), .rstN(rstN), .pcSel(pcSel), .brnchAddr(brnchAddr),
      .issue(issue), .pc(pc)
   );

   always #2 clk = ~clk;

   // Control set per opcode, written from the opcode table
   function automatic fetchPkg::ctrlT decodeRef(input logic [4:0] op);
      fetchPkg::ctrlT c;
      c = '0;
      case (op)
         5'b00000: c.halt = 1'b1;
         5'b00001: c = '0;
         5'b00100: begin
            c.jFlag = 1'b1;
            c.immSel = 3'd4;
         end
         5'b00101: begin
            c.jFlag = 1'b1;
            c.regJmp = 1'b1;
            c.immSel = 3'd2;
            c.validRs = 1'b1;
         end
         5'b00110: begin
            c.regWrite = 1'b1;
            c.destSel = fetchPkg::dstR7;
            c.link = 1'b1;
            c.jFlag = 1'b1;
            c.immSel = 3'd4;
         end
         5'b01000, 5'b01001: begin
            c.regWrite = 1'b1;
            c.destSel = fetchPkg::dstRdI;
            c.aluSel = 1'b1;
            c.validRs = 1'b1;
         end
         5'b01100: begin
            c.bFlag = 1'b1;
            c.immSel = 3'd2;
            c.validRs = 1'b1;
         end
         5'b10000: begin
            c.memEnable = 1'b1;
            c.memWr = 1'b1;
            c.aluSel = 1'b1;
            c.validRs = 1'b1;
            c.validRt = 1'b1;
         end
         5'b10001: begin
            c.regWrite = 1'b1;
            c.destSel = fetchPkg::dstRdI;
            c.memEnable = 1'b1;
            c.val2Reg = 1'b1;
            c.aluSel = 1'b1;
            c.validRs = 1'b1;
         end
         5'b11000: begin
            c.regWrite = 1'b1;
            c.destSel = fetchPkg::dstRs;
            c.lbi = 1'b1;
            c.immSel = 3'd2;
         end
         5'b11011: begin
            c.regWrite = 1'b1;
            c.destSel = fetchPkg::dstRdR;
            c.validRs = 1'b1;
            c.validRt = 1'b1;
         end
         default: c.ctrlErr = 1'b1;
      endcase
      return c;
   endfunction

   function automatic logic [2:0] destOf(input logic [15:0] w, input fetchPkg::destSelE s);
      logic [2:0] d;
      case (s)
         fetchPkg::dstRs:  d = w[10:8];
         fetchPkg::dstRdR: d = w[4:2];
         fetchPkg::dstR7:  d = 3'd7;
         default:          d = w[7:5];
      endcase
      return d;
   endfunction

   // RAW hit of the used sources against the tracked destinations
   function automatic logic rawStall(
      input logic [15:0]     word,
      input logic [2:0]      sbV,
      input logic [2:0][2:0] sbA
   );
      fetchPkg::ctrlT c;
      logic           hit;
      c = decodeRef(word[15:11]);
      hit = 1'b0;
      for (int i = 0; i < 3; i++) begin
         if (sbV[i] && ((c.validRs && sbA[i] == word[10:8]) ||
                        (c.validRt && sbA[i] == word[7:5]))) begin
            hit = 1'b1;
         end
      end
      return hit;
   endfunction

   // Expected record for the word at pcIn, plus the model state after the edge
   function automatic fetchPkg::issueT predictIssue(
      input  logic [15:0]     pcIn,
      input  logic [2:0]      sbV,
      input  logic [2:0][2:0] sbA,
      input  logic            halt,
      input  logic            sel,
      input  logic [15:0]     tgt,
      output logic [15:0]     nPc,
      output logic [2:0]      nSbV,
      output logic [2:0][2:0] nSbA,
      output logic            nHalt
   );
      logic [15:0]       word;
      logic [15:0]       iw;
      logic signed [10:0] disp;
      fetchPkg::ctrlT    c;
      fetchPkg::ctrlT    ic;
      logic              stallV;
      logic              useNop;
      fetchPkg::issueT   r;
      word = progMem[pcIn[8:1]];
      c = decodeRef(word[15:11]);
      stallV = rawStall(word, sbV, sbA);
      useNop = stallV || halt;
      iw = useNop ? 16'h0800 : word;
      ic = decodeRef(iw[15:11]);
      r.valid = !useNop;
      r.pc = pcIn;
      r.instr = iw;
      r.writeRegAddr = destOf(iw, ic.destSel);
      r.ctrl = ic;
      nSbV = {sbV[1:0], c.regWrite && !useNop};
      nSbA = {sbA[1:0], destOf(word, c.destSel)};
      nHalt = halt || (c.halt && !useNop);
      disp = word[10:0];
      if (sel) begin
         nPc = tgt;
      end
      else if (useNop) begin
         nPc = pcIn;
      end
      else if (word[15:11] == 5'b00100 || word[15:11] == 5'b00110) begin
         nPc = pcIn + 16'd2 + 16'(disp);
      end
      else begin
         nPc = pcIn + 16'd2;
      end
      return r;
   endfunction

   // Early redirects into the NOP area above the program
   // The first lands on a cycle the model predicts as stalled
   always @(posedge clk) begin
      if (!rstN) begin
         stallRedir <= 1'b0;
      end
      else begin
         cycle <= cycle + 1;
      end
      if (rstN && cycle >= 10 && cycle < 40 && !mHalted) begin
         if (!stallRedir) begin
            pcSel      <= mStallNext;
            stallRedir <= mStallNext;
         end
         else begin
            pcSel <= (($random(seed) & 3) == 0);
         end
         brnchAddr <= 16'(($unsigned($random(seed)) % 224) + 32) << 1;
      end
      else begin
         pcSel <= 1'b0;
      end
   end

   // Compare at the falling edge, then step the model
   always @(negedge clk) begin
      if (!rstN) begin
         mPc        = '0;
         mSbV       = '0;
         mSbA       = '0;
         mHalted    = 1'b0;
         mStallNext = 1'b0;
         expIssue   = '0;
         expIssue.instr = 16'h0800;
      end
      else begin
         checkCount = checkCount + 1;
         if (pc !== mPc) begin
            $display("Error pc: got %h, expected %h", pc, mPc);
            errCount = errCount + 1;
         end
         if (issue !== expIssue) begin
            $display("Error issue: got %h, expected %h", issue, expIssue);
            errCount = errCount + 1;
         end
         if (issue.valid && issue.ctrl.halt) begin
            haltSeen = 1'b1;
         end
         expIssue = predictIssue(mPc, mSbV, mSbA, mHalted, pcSel, brnchAddr,
                                 mPc, mSbV, mSbA, mHalted);
         mStallNext = rawStall(progMem[mPc[8:1]], mSbV, mSbA) && !mHalted;
      end
   end

   initial begin
      clk        = 1'b0;
      rstN       = 1'b0;
      pcSel      = 1'b0;
      brnchAddr  = '0;
      seed       = 32'h28b8e69d;
      errCount   = 0;
      checkCount = 0;
      cycle      = 0;
      haltSeen   = 1'b0;
      timedOut   = 1'b0;
      for (int i = 0; i < 256; i++) begin
         progMem[i] = 16'h0800;
      end
      $readmemh("dv/imem.hex", progMem);

      repeat (4) @(posedge clk);
      rstN <= 1'b1;

      for (int w = 0; w < 2000 && !haltSeen; w++) begin
         @(posedge clk);
      end
      if (!haltSeen) begin
         $display("Timed out waiting for HALT to issue");
         timedOut = 1'b1;
      end
      else begin
         @(negedge clk);
         frozenPc = mPc;
         for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            if (pc !== frozenPc) begin
               $display("Error pc after halt: got %h, expected %h", pc, frozenPc);
               errCount = errCount + 1;
            end
            if (issue.valid !== 1'b0) begin
               $display("Error issue.valid after halt: got %h, expected %h",
                        issue.valid, 1'b0);
               errCount = errCount + 1;
            end
            if (issue.instr !== 16'h0800) begin
               $display("Error issue.instr after halt: got %h, expected %h",
                        issue.instr, 16'h0800);
               errCount = errCount + 1;
            end
         end
      end

      if (!stallRedir) begin
         $display("No redirect was applied during a stalled cycle");
         errCount = errCount + 1;
      end

      $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errCount, timedOut);
      if (errCount == 0 && !timedOut) begin
         $display("TB PASSED");
      end
      else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* dv/imem.hex */
// One 16-bit instruction word per line, opcode in bits 15:11
// Word index order from address 0
C105 // LBI r1
4141 // ADDI r2 = r1, reader right after writer
C310 // LBI r3
0800
4382 // ADDI r4 = r3, two after
C507 // LBI r5
0800
0800
DD18 // ALU r6 = r5, three after
2004 // J +4
F800
F800
3002 // JAL +2
F800
1000 // Illegal opcode
87C0 // ST reads r7 and r6
6204 // BEQZ r2
2900 // JR r1
8C20 // LD r1
4941 // SUBI r2 = r1
0800
0000 // HALT

/* fetchStage.f */
rtl/fetchPkg.sv
rtl/progCounter.sv
rtl/instrMem.sv
rtl/ctrlDecoder.sv
rtl/hazardUnit.sv
rtl/fetchStage.sv
dv/fetchStageTb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = fetchStageTb
FILELIST  = fetchStage.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The ROM loads imem.hex from the working directory
run: compile
	cp dv/imem.hex imem.hex
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG) imem.hex
